// File: hdl/tpu_pkg.sv
// TPU-side types for a fixed 2 by 2 grid; one enable bit per TPU, no per-TPU back-pressure
package tpu_pkg;

	////////////////////////////////////////
	// Grid size
	////////////////////////////////////////
	localparam int NUM_ROW		= 2;
	localparam int NUM_CLM		= 2;
	localparam int NUM_TPU		= NUM_ROW * NUM_CLM;

	localparam int WIDTH_INSTR	= 32;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////
	typedef logic [WIDTH_INSTR-1:0]	instr_t;			// One instruction word
	typedef logic [NUM_TPU-1:0]		tpu_row_clm_t;		// Bit per TPU, row major

endpackage

// File: hdl/mpu_pkg.sv
// Management-unit sizes are fixed here; thread memory is append-only and is never reclaimed
package mpu_pkg;
	import tpu_pkg::*;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////
	localparam int THREAD_MEM_DEPTH	= 64;
	localparam int NUM_THREADS		= 8;
	localparam int NUM_ISSUE		= 4;

	localparam int WIDTH_T_ADDR		= $clog2(THREAD_MEM_DEPTH);
	localparam int WIDTH_LENGTH		= WIDTH_T_ADDR + 1;		// Room for a full-memory length
	localparam int WIDTH_ID			= $clog2(NUM_THREADS);
	localparam int WIDTH_ISSUE		= $clog2(NUM_ISSUE);

	////////////////////////////////////////
	// Types
	////////////////////////////////////////
	typedef logic [WIDTH_T_ADDR-1:0]	t_address_t;
	typedef logic [WIDTH_LENGTH-1:0]	t_length_t;
	typedef logic [WIDTH_ID-1:0]		id_t;
	typedef logic [WIDTH_ISSUE-1:0]		mpu_issue_no_t;		// Wraps around

	typedef struct packed {
		t_address_t	base;
		t_length_t	length;			// Zero for a thread never stored
	} lookup_t;

	typedef struct packed {
		id_t		id;
		logic		last;			// Closes the thread
		instr_t		instr;
	} mpu_store_t;

	typedef struct packed {
		logic		busy;
		logic		mem_full;		// Sticky
		logic		commit_full;
		logic		commit_err;		// Sticky
	} mpu_stat_t;

endpackage

// File: hdl/thread_mem.sv
// Words of one thread must arrive back to back; once full, every later store is dropped
module thread_mem
	import mpu_pkg::*;
	import tpu_pkg::*;
(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			store_req,
	input	mpu_store_t		store_data,
	input	t_address_t		rd_addr,
	output	instr_t			rd_instr,
	output	logic			thread_done,
	output	id_t			done_id,
	output	lookup_t		done_info,
	output	logic			mem_full
);

	instr_t			mem [THREAD_MEM_DEPTH];
	t_length_t		wr_ptr;			// Next free word, equals depth when full
	t_address_t		start;			// Base of the thread being stored
	logic			full;
	logic			wr_en;

	assign full		= (wr_ptr == t_length_t'(THREAD_MEM_DEPTH));
	assign wr_en	= store_req && !full;

	////////////////////////////////////////
	// Write pointer and flags
	////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr		<= '0;
			start		<= '0;
			thread_done	<= 1'b0;
			mem_full	<= 1'b0;
		end else begin
			thread_done <= wr_en && store_data.last;
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
				if (store_data.last) begin
					start <= t_address_t'(wr_ptr + 1'b1);	// Next thread starts here
				end
			end
			if (store_req && full) begin
				mem_full <= 1'b1;		// Held until reset
			end
		end
	end

	////////////////////////////////////////
	// Storage and read port
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[t_address_t'(wr_ptr)] <= store_data.instr;
		end
		if (wr_en && store_data.last) begin
			done_id				<= store_data.id;
			done_info.base		<= start;
			done_info.length	<= wr_ptr - t_length_t'(start) + 1'b1;	// Includes last word
		end
		rd_instr <= mem[rd_addr];		// One cycle of latency
	end

endmodule

// File: hdl/map_man.sv
// Entries are overwritten when an id is stored again; a store in the lookup cycle is forwarded
module map_man
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			thread_done,
	input	id_t			done_id,
	input	lookup_t		done_info,
	input	id_t			lookup_id,
	output	lookup_t		lookup_info
);

	lookup_t		map_tbl [NUM_THREADS];
	logic			fwd;

	// New entry for the id being looked up
	assign fwd = thread_done && (done_id == lookup_id);

	////////////////////////////////////////
	// Thread table
	////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_THREADS; i++) begin
				map_tbl[i] <= '0;		// Length 0 marks an empty id
			end
		end else if (thread_done) begin
			map_tbl[done_id] <= done_info;
		end
	end

	////////////////////////////////////////
	// Registered lookup
	////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			lookup_info <= '0;
		end else if (fwd) begin
			lookup_info <= done_info;
		end else begin
			lookup_info <= map_tbl[lookup_id];
		end
	end

endmodule

// File: hdl/issue_ctrl.sv
// Holds one launch at a time; launches that arrive while busy are ignored, not queued
module issue_ctrl
	import mpu_pkg::*;
	import tpu_pkg::*;
(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			launch_req,
	input	id_t			launch_id,
	input	tpu_row_clm_t	launch_mask,
	input	logic			commit_full,
	input	logic			dispatch_done,
	output	logic			issue_req,
	output	id_t			issue_id,
	output	mpu_issue_no_t	issue_no,
	output	tpu_row_clm_t	issue_mask,
	output	logic			busy
);

	typedef enum logic [1:0] {ST_IDLE, ST_PEND, ST_DISP} state_t;

	state_t			state;
	mpu_issue_no_t	next_no;		// Number for the next issue
	logic			accept;

	assign accept		= launch_req && (state == ST_IDLE);
	assign busy			= (state != ST_IDLE);
	assign issue_req	= (state == ST_PEND) && !commit_full;	// Held while window full
	assign issue_no		= next_no;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state		<= ST_IDLE;
			next_no		<= '0;
			issue_id	<= '0;
			issue_mask	<= '0;
		end else begin
			if (accept) begin
				issue_id	<= launch_id;
				issue_mask	<= launch_mask;
			end
			case (state)
				ST_IDLE:	if (accept) state <= ST_PEND;
				ST_PEND:	if (issue_req) begin
								state	<= ST_DISP;
								next_no	<= next_no + 1'b1;
							end
				ST_DISP:	if (dispatch_done) state <= ST_IDLE;
				default:	state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/commit_track.sv
// A number is free again only after its commit; commits of free numbers only raise the error
module commit_track
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			issue_req,
	input	mpu_issue_no_t	issue_no,
	input	logic			commit_req,
	input	mpu_issue_no_t	commit_no,
	output	logic			commit_full,
	output	logic			commit_err
);

	logic [NUM_ISSUE-1:0]	inflight;		// Bit per issue number
	logic [NUM_ISSUE-1:0]	set_mask;
	logic [NUM_ISSUE-1:0]	clr_mask;
	logic					commit_ok;

	assign commit_ok	= commit_req && inflight[commit_no];
	assign commit_full	= &inflight;

	////////////////////////////////////////
	// One-hot updates
	////////////////////////////////////////
	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (issue_req) begin
			set_mask[issue_no] = 1'b1;
		end
		if (commit_ok) begin
			clr_mask[commit_no] = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			inflight	<= '0;
			commit_err	<= 1'b0;
		end else begin
			inflight <= (inflight | set_mask) & ~clr_mask;	// Issue and commit may coincide
			if (commit_req && !inflight[commit_no]) begin
				commit_err <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/dispatch.sv
// Streams one instruction per cycle with no stall; the TPUs must take every word
module dispatch
	import mpu_pkg::*;
	import tpu_pkg::*;
(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			issue_req,
	input	id_t			issue_id,
	input	mpu_issue_no_t	issue_no,
	input	tpu_row_clm_t	issue_mask,
	output	id_t			lookup_id,
	input	lookup_t		lookup_info,
	output	t_address_t		rd_addr,
	input	instr_t			rd_instr,
	output	logic			instr_valid,
	output	instr_t			instr,
	output	mpu_issue_no_t	issue_no_out,
	output	tpu_row_clm_t	tpu_en,
	output	logic			dispatch_done
);

	typedef enum logic [1:0] {PH_IDLE, PH_LOOKUP, PH_STREAM} phase_t;

	phase_t			phase;
	t_length_t		remain;			// Reads still to issue
	t_address_t		addr_q;
	logic			valid_d;		// Tracks memory latency
	mpu_issue_no_t	no_q;
	tpu_row_clm_t	mask_q;

	assign lookup_id	= issue_id;
	assign rd_addr		= (phase == PH_LOOKUP) ? lookup_info.base : addr_q;
	assign instr_valid	= valid_d;
	assign instr		= rd_instr;
	assign issue_no_out	= no_q;
	assign tpu_en		= valid_d ? mask_q : '0;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			phase			<= PH_IDLE;
			remain			<= '0;
			addr_q			<= '0;
			valid_d			<= 1'b0;
			no_q			<= '0;
			mask_q			<= '0;
			dispatch_done	<= 1'b0;
		end else begin
			dispatch_done <= 1'b0;
			case (phase)
				PH_IDLE: if (issue_req) begin
					no_q	<= issue_no;
					mask_q	<= issue_mask;
					phase	<= PH_LOOKUP;
				end
				PH_LOOKUP: if (lookup_info.length == '0) begin
					dispatch_done	<= 1'b1;		// Nothing to stream
					phase			<= PH_IDLE;
				end else begin
					valid_d	<= 1'b1;			// First read goes out this cycle
					addr_q	<= lookup_info.base + 1'b1;
					remain	<= lookup_info.length - 1'b1;
					phase	<= PH_STREAM;
				end
				PH_STREAM: if (remain != '0) begin
					addr_q	<= addr_q + 1'b1;
					remain	<= remain - 1'b1;
				end else begin
					valid_d			<= 1'b0;		// Last word is on the stream now
					dispatch_done	<= 1'b1;
					phase			<= PH_IDLE;
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/mpu.sv
// Top level; stores and launches use plain strobes and the TPU stream has no back-pressure
module mpu
	import mpu_pkg::*;
	import tpu_pkg::*;
(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			store_req,
	input	mpu_store_t		store_data,
	input	logic			launch_req,
	input	id_t			launch_id,
	input	tpu_row_clm_t	launch_mask,
	input	logic			commit_req,
	input	mpu_issue_no_t	commit_no,
	output	logic			instr_valid,
	output	instr_t			instr,
	output	mpu_issue_no_t	issue_no,
	output	logic			tpu_req,
	output	tpu_row_clm_t	tpu_en,
	output	mpu_stat_t		status
);

	t_address_t		rd_addr;
	instr_t			rd_instr;
	logic			thread_done;
	id_t			done_id;
	lookup_t		done_info;
	id_t			lookup_id;
	lookup_t		lookup_info;
	logic			iss_req;
	id_t			iss_id;
	mpu_issue_no_t	iss_no;
	tpu_row_clm_t	iss_mask;
	logic			busy;
	logic			mem_full;
	logic			commit_full;
	logic			commit_err;
	logic			dispatch_done;

	assign tpu_req	= |tpu_en;		// Any TPU enabled
	assign status	= '{busy: busy, mem_full: mem_full, commit_full: commit_full,
						commit_err: commit_err};

	thread_mem u_thread_mem (.clock(clock), .arst_n(arst_n), .store_req(store_req),
		.store_data(store_data), .rd_addr(rd_addr), .rd_instr(rd_instr),
		.thread_done(thread_done), .done_id(done_id), .done_info(done_info), .mem_full(mem_full));

	map_man u_map_man (.clock(clock), .arst_n(arst_n), .thread_done(thread_done),
		.done_id(done_id), .done_info(done_info), .lookup_id(lookup_id), .lookup_info(lookup_info));

	issue_ctrl u_issue_ctrl (.clock(clock), .arst_n(arst_n), .launch_req(launch_req),
		.launch_id(launch_id), .launch_mask(launch_mask), .commit_full(commit_full),
		.dispatch_done(dispatch_done), .issue_req(iss_req), .issue_id(iss_id),
		.issue_no(iss_no), .issue_mask(iss_mask), .busy(busy));

	commit_track u_commit_track (.clock(clock), .arst_n(arst_n), .issue_req(iss_req),
		.issue_no(iss_no), .commit_req(commit_req), .commit_no(commit_no),
		.commit_full(commit_full), .commit_err(commit_err));

	dispatch u_dispatch (.clock(clock), .arst_n(arst_n), .issue_req(iss_req), .issue_id(iss_id),
		.issue_no(iss_no), .issue_mask(iss_mask), .lookup_id(lookup_id),
		.lookup_info(lookup_info), .rd_addr(rd_addr), .rd_instr(rd_instr),
		.instr_valid(instr_valid), .instr(instr), .issue_no_out(issue_no), .tpu_en(tpu_en),
		.dispatch_done(dispatch_done));

endmodule

// File: verification/mpu_props.sv
// Assertions assume the stream has no back-pressure; mem_full may only clear through arst_n
module mpu_props
	import mpu_pkg::*;
	import tpu_pkg::*;
(
	input	logic			clock,
	input	logic			arst_n,
	input	logic			instr_valid,
	input	logic			tpu_req,
	input	tpu_row_clm_t	tpu_en,
	input	mpu_stat_t		status
);

	int fail_count = 0;		// Read by the testbench

	a_valid_req: assert property (@(posedge clock) disable iff (!arst_n)
		instr_valid |-> tpu_req)
		else begin
			fail_count++;
			$error("instr_valid high while tpu_req is low");
		end

	a_en_idle: assert property (@(posedge clock) disable iff (!arst_n)
		!instr_valid |-> (tpu_en == '0))
		else begin
			fail_count++;
			$error("tpu_en set while instr_valid is low");
		end

	a_mem_full_sticky: assert property (@(posedge clock) disable iff (!arst_n)
		status.mem_full |=> status.mem_full)
		else begin
			fail_count++;
			$error("status.mem_full fell without a reset");
		end

endmodule

bind mpu mpu_props u_props (.clock(clock), .arst_n(arst_n), .instr_valid(instr_valid),
	.tpu_req(tpu_req), .tpu_en(tpu_en), .status(status));

// File: verification/mpu_tb.sv
// Stimulus path is relative to the project root; launches wait for busy low before driving
module mpu_tb
	import mpu_pkg::*;
	import tpu_pkg::*;
();

	logic			clock;
	logic			arst_n;
	logic			store_req;
	mpu_store_t		store_data;
	logic			launch_req;
	id_t			launch_id;
	tpu_row_clm_t	launch_mask;
	logic			commit_req;
	mpu_issue_no_t	commit_no;
	logic			instr_valid;
	instr_t			instr;
	mpu_issue_no_t	issue_no;
	logic			tpu_req;
	tpu_row_clm_t	tpu_en;
	mpu_stat_t		status;

	int				errors;
	int				checks;
	bit				loaded;
	int				limit_cycles;
	logic [7:0]		cmd_q [$];		// One entry per command line
	logic [31:0]	arg_a [$];
	logic [31:0]	arg_b [$];
	logic [31:0]	arg_c [$];
	int				fill_words;

	////////////////////////////////////////
	// Reference model state
	////////////////////////////////////////
	instr_t			map_words [NUM_THREADS][THREAD_MEM_DEPTH];
	int				map_len [NUM_THREADS];
	instr_t			cur_words [THREAD_MEM_DEPTH];		// Thread being stored
	int				cur_len;
	int				mdl_ptr;
	logic [NUM_ISSUE-1:0]	mdl_inflight;
	mpu_issue_no_t	mdl_no;
	bit				stall_pending;		// Launch held by a full window
	mpu_issue_no_t	stall_no;
	id_t			stall_id;
	tpu_row_clm_t	stall_mask;
	instr_t			exp_instr [$];
	mpu_issue_no_t	exp_no [$];
	tpu_row_clm_t	exp_mask [$];
	logic			exp_first [$];
	bit				in_stream;

	mpu dut (.clock(clock), .arst_n(arst_n), .store_req(store_req), .store_data(store_data),
		.launch_req(launch_req), .launch_id(launch_id), .launch_mask(launch_mask),
		.commit_req(commit_req), .commit_no(commit_no), .instr_valid(instr_valid),
		.instr(instr), .issue_no(issue_no), .tpu_req(tpu_req), .tpu_en(tpu_en),
		.status(status));

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic load_stimulus(output bit ok);
		int				fd;
		int				r;
		logic [7:0]		cmd;
		logic [31:0]	a;
		logic [31:0]	b;
		logic [31:0]	v;
		string			line;
		fd = $fopen("verification/mpu_stim.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			r = $fscanf(fd, " %c", cmd);
			while (r == 1) begin
				a = '0;
				b = '0;
				v = '0;
				case (cmd)
					"S":		r = $fscanf(fd, "%d %d %h", a, b, v);
					"F":		r = $fscanf(fd, "%d %d", a, b);
					"L":		r = $fscanf(fd, "%d %h", a, b);
					"C":		r = $fscanf(fd, "%d", a);
					"X":		r = $fscanf(fd, "%b", a);		// busy, mem_full, full, err
					default:	r = $fgets(line, fd);			// Comment or unknown
				endcase
				if (cmd != "#") begin
					cmd_q.push_back(cmd);
					arg_a.push_back(a);
					arg_b.push_back(b);
					arg_c.push_back(v);
					if (cmd == "F") begin
						fill_words += b;
					end
				end
				r = $fscanf(fd, " %c", cmd);
			end
			$fclose(fd);
		end
	endtask

	task automatic predict_store(input id_t id, input logic last, input instr_t w);
		if (mdl_ptr < THREAD_MEM_DEPTH) begin
			cur_words[cur_len] = w;
			cur_len++;
			mdl_ptr++;
			if (last) begin
				for (int k = 0; k < cur_len; k++) begin
					map_words[id][k] = cur_words[k];
				end
				map_len[id] = cur_len;
				cur_len = 0;
			end
		end
	endtask

	task automatic expect_stream(input id_t id, input tpu_row_clm_t mask,
			input mpu_issue_no_t no);
		for (int k = 0; k < map_len[id]; k++) begin
			exp_instr.push_back(map_words[id][k]);
			exp_no.push_back(no);
			exp_mask.push_back(mask);
			exp_first.push_back(k == 0);
		end
	endtask

	task automatic store_word(input id_t id, input logic last, input instr_t w);
		@(posedge clock);
		#1;
		store_req = 1'b1;
		store_data = '{id: id, last: last, instr: w};
		predict_store(id, last, w);
	endtask

	task automatic release_store();
		@(posedge clock);
		#1;
		store_req = 1'b0;
	endtask

	task automatic fill_thread(input id_t id, input int count);
		int		base;
		instr_t	w;
		base = mdl_ptr;
		for (int k = 0; k < count; k++) begin
			w = 32'hc3a5_0000 ^ (32'(base + k) * 32'h0101_0101);	// Whole address in each byte
			store_word(id, (k == count - 1), w);
		end
		release_store();
	endtask

	task automatic launch_thread(input id_t id, input tpu_row_clm_t mask);
		while (status.busy) begin
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		launch_req = 1'b1;
		launch_id = id;
		launch_mask = mask;
		if (&mdl_inflight) begin
			stall_pending = 1'b1;		// Waits for a commit
			stall_no = mdl_no;
			stall_id = id;
			stall_mask = mask;
		end else begin
			mdl_inflight[mdl_no] = 1'b1;
			expect_stream(id, mask, mdl_no);
		end
		mdl_no++;
		@(posedge clock);
		#1;
		launch_req = 1'b0;
	endtask

	task automatic commit_number(input mpu_issue_no_t n);
		@(posedge clock);
		#1;
		commit_req = 1'b1;
		commit_no = n;
		if (mdl_inflight[n]) begin
			mdl_inflight[n] = 1'b0;
			if (stall_pending) begin
				mdl_inflight[stall_no] = 1'b1;
				stall_pending = 1'b0;
				expect_stream(stall_id, stall_mask, stall_no);	// Held launch streams now
			end
		end
		@(posedge clock);
		#1;
		commit_req = 1'b0;
	endtask

	task automatic check_status(input logic [3:0] exp);
		// Settled when idle with no words due, or held by a full window
		while (!((!status.busy && exp_instr.size() == 0) || (stall_pending && status.busy))) begin
			@(negedge clock);
		end
		check_value("status.busy", exp[3], status.busy);
		check_value("status.mem_full", exp[2], status.mem_full);
		check_value("status.commit_full", exp[1], status.commit_full);
		check_value("status.commit_err", exp[0], status.commit_err);
	endtask

	////////////////////////////////////////
	// Stream monitor
	////////////////////////////////////////
	always @(negedge clock) begin
		if (arst_n) begin
			if (instr_valid && exp_instr.size() == 0) begin
				errors++;
				$display("Error t=%0t instruction streamed with none expected", $time);
			end else if (instr_valid) begin
				check_value("instr", exp_instr[0], instr);
				check_value("issue_no", exp_no[0], issue_no);
				check_value("tpu_en", exp_mask[0], tpu_en);
				check_value("tpu_req", 1'b1, tpu_req);
				void'(exp_instr.pop_front());
				void'(exp_no.pop_front());
				void'(exp_mask.pop_front());
				void'(exp_first.pop_front());
				in_stream = (exp_first.size() != 0) && !exp_first[0];	// More of this thread
			end else begin
				if (in_stream) begin
					errors++;
					$display("Error t=%0t stream stopped before the thread ended", $time);
				end
				in_stream = 1'b0;
				check_value("tpu_en", '0, tpu_en);
				check_value("tpu_req", 1'b0, tpu_req);
			end
		end
	end

	initial begin : watchdog
		wait (loaded);
		repeat (limit_cycles) @(posedge clock);
		$display("Timeout: stimulus did not finish within %0d cycles", limit_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : main
		bit ok;
		int gap;
		void'($urandom(32'h591f42e7));
		arst_n = 1'b0;
		store_req = 1'b0;
		store_data = '0;
		launch_req = 1'b0;
		launch_id = '0;
		launch_mask = '0;
		commit_req = 1'b0;
		commit_no = '0;
		mdl_inflight = '0;
		mdl_no = '0;
		load_stimulus(ok);
		if (!ok) begin
			$display("Error: cannot open verification/mpu_stim.txt");
			$display("FAIL: see errors above");
			$finish;
		end else begin
			limit_cycles = cmd_q.size() * 40 + fill_words + 200;
			loaded = 1'b1;
			repeat (16) @(posedge clock);
			#1;
			arst_n = 1'b1;
			check_value("instr_valid", 1'b0, instr_valid);
			check_value("tpu_req", 1'b0, tpu_req);
			check_value("tpu_en", '0, tpu_en);
			check_value("status", '0, status);
			for (int i = 0; i < cmd_q.size(); i++) begin
				gap = $urandom_range(3, 0);		// Idle cycles between commands
				repeat (gap) @(posedge clock);
				case (cmd_q[i])
					"S": begin
						store_word(id_t'(arg_a[i]), arg_b[i][0], arg_c[i]);
						release_store();
					end
					"F":		fill_thread(id_t'(arg_a[i]), arg_b[i]);
					"L":		launch_thread(id_t'(arg_a[i]), tpu_row_clm_t'(arg_b[i]));
					"C":		commit_number(mpu_issue_no_t'(arg_a[i]));
					"X":		check_status(arg_a[i][3:0]);
					default: begin
						errors++;
						$display("Error: unknown stimulus command %c", cmd_q[i]);
					end
				endcase
			end
			while (status.busy) begin
				@(negedge clock);
			end
			@(negedge clock);
			if (exp_instr.size() != 0) begin
				errors++;
				$display("Error: %0d expected words were never streamed", exp_instr.size());
			end
			$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
				dut.u_props.fail_count);
			if (errors == 0 && dut.u_props.fail_count == 0) begin
				$display("PASS: all tests");
			end else begin
				$display("FAIL: see errors above");
			end
			$finish;
		end
	end

endmodule

// File: verification/mpu_stim.txt
# Columns: S id last instr(hex) | F id count | L id mask(hex) | C number
# X expects status bits busy mem_full commit_full commit_err
X 0000
S 1 0 11110001
S 1 0 22220002
S 1 1 33330003
S 2 1 44440004
L 1 5
L 2 a
X 0000
L 7 3
L 1 f
X 0010
L 2 6
X 1010
C 0
X 0010
C 1
C 2
C 1
X 0001
F 2 66
X 0101
L 2 9
L 3 c
X 0111
C 3
C 0
L 1 c
X 0101

// File: sources.f
hdl/tpu_pkg.sv
hdl/mpu_pkg.sv
hdl/thread_mem.sv
hdl/map_man.sv
hdl/issue_ctrl.sv
hdl/commit_track.sv
hdl/dispatch.sv
hdl/mpu.sv
verification/mpu_props.sv
verification/mpu_tb.sv
